/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // register offsets
  localparam logic [7:0] ADDR_TDR = 8'h00;
  localparam logic [7:0] ADDR_RDR = 8'h04;
  localparam logic [7:0] ADDR_LCR = 8'h08;
  localparam logic [7:0] ADDR_LSR = 8'h0C;
  localparam logic [7:0] ADDR_IER = 8'h10;
  localparam logic [7:0] ADDR_IIR = 8'h14;

  // line status bits
  localparam int LSR_TX_EMPTY  = 0;
  localparam int LSR_TX_FULL   = 1;
  localparam int LSR_RX_AVAIL  = 2;
  localparam int LSR_OVERRUN   = 3;
  localparam int LSR_FRAME_ERR = 4;
  localparam int LSR_WIDTH     = 5;

  // interrupt causes, same layout in IER and IIR
  localparam int IIR_RX       = 0;
  localparam int IIR_TX_EMPTY = 1;
  localparam int IIR_LINE     = 2;
  localparam int IIR_WIDTH    = 3;

  // ticks per serial bit
  localparam int OVERSAMPLE = 16;

  // one received character with its stop bit check
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;
  } rx_item_t;

endpackage

`default_nettype wire

/* uart_fifo.sv */
`default_nettype none

module uart_fifo #(
  parameter int  FIFO_DEPTH = 8,
  parameter type item_t     = logic [7:0]
) (
  input  wire logic  apb_if,
  input  wire logic  arst_n,
  input  wire logic  push,
  input  wire item_t wdata,
  input  wire logic  pop,
  output item_t      rdata,
  output logic       full,
  output logic       empty
);

  localparam int AW = $clog2(FIFO_DEPTH);

  item_t mem [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [AW:0]   count_next;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + 1'b1;
    end else if (do_pop && !do_push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge apb_if) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= (count_next == (AW+1)'(FIFO_DEPTH));
      empty <= (count_next == '0);
    end
  end

  assign rdata = mem[rd_ptr];

endmodule

`default_nettype wire

/* uart_baud_gen.sv */
`default_nettype none

module uart_baud_gen (
  input  wire logic        apb_if,
  input  wire logic        arst_n,
  input  wire logic [15:0] divisor,
  output logic             tick
);

  logic [15:0] cnt;
  logic [15:0] div_q;

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      cnt   <= '0;
      div_q <= '0;
      tick  <= 1'b0;
    end else if (divisor != div_q) begin
      // new rate, start a fresh period
      div_q <= divisor;
      cnt   <= divisor;
      tick  <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= div_q;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx (
  input  wire logic       apb_if,
  input  wire logic       arst_n,
  input  wire logic       tick,
  input  wire logic       empty,
  input  wire logic [7:0] data,
  output logic            pop,
  output logic            txd
);

  localparam int TW = $clog2(uart_pkg::OVERSAMPLE);

  typedef enum logic [1:0] {
    TX_IDLE  = 2'b00,
    TX_START = 2'b01,
    TX_DATA  = 2'b10,
    TX_STOP  = 2'b11
  } tx_state_e;

  tx_state_e     state;
  logic [TW-1:0] tick_cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    shift;
  logic          bit_end;

  assign bit_end = tick && (tick_cnt == TW'(uart_pkg::OVERSAMPLE - 1));

  // frames start on a tick, back to back frames skip idle
  assign pop = tick && !empty &&
               ((state == TX_IDLE) || ((state == TX_STOP) && bit_end));

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else if (pop) begin
      state    <= TX_START;
      tick_cnt <= '0;
      txd      <= 1'b0;
    end else if (tick && (state != TX_IDLE)) begin
      tick_cnt <= tick_cnt + 1'b1;
      if (bit_end) begin
        case (state)
          TX_START: begin
            state   <= TX_DATA;
            bit_cnt <= '0;
            txd     <= shift[0];
          end
          TX_DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= TX_STOP;
              txd   <= 1'b1;
            end else begin
              txd <= shift[1];
            end
          end
          default: begin
            state <= TX_IDLE;
            txd   <= 1'b1;
          end
        endcase
      end
    end
  end

  // lsb first
  always_ff @(posedge apb_if) begin
    if (pop) begin
      shift <= data;
    end else if (bit_end && (state == TX_DATA)) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx (
  input  wire logic         apb_if,
  input  wire logic         arst_n,
  input  wire logic         tick,
  input  wire logic         rxd,
  input  wire logic         full,
  output logic              push,
  output uart_pkg::rx_item_t item,
  output logic              overrun
);

  localparam int TW = $clog2(uart_pkg::OVERSAMPLE);

  typedef enum logic [1:0] {
    RX_IDLE  = 2'b00,
    RX_START = 2'b01,
    RX_DATA  = 2'b10,
    RX_STOP  = 2'b11
  } rx_state_e;

  rx_state_e     state;
  logic [1:0]    sync;
  logic          rx_s;
  logic          rx_last;
  logic [TW-1:0] tick_cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    shift;
  logic          mid_bit;
  logic          stop_done;

  assign rx_s = sync[1];

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  // data and stop are sampled one full bit after the previous sample
  assign mid_bit   = tick && (tick_cnt == TW'(uart_pkg::OVERSAMPLE - 1));
  assign stop_done = (state == RX_STOP) && mid_bit;

  always_comb begin
    item.data      = shift;
    item.frame_err = !rx_s;
  end

  assign push    = stop_done && !full;
  assign overrun = stop_done && full;

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      state    <= RX_IDLE;
      rx_last  <= 1'b1;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tick) begin
      rx_last  <= rx_s;
      tick_cnt <= tick_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          if (rx_last && !rx_s) begin
            state    <= RX_START;
            tick_cnt <= '0;
          end
        end
        RX_START: begin
          // half a bit in, line must still be low
          if (tick_cnt == TW'(uart_pkg::OVERSAMPLE/2 - 1)) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (mid_bit) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge apb_if) begin
    if ((state == RX_DATA) && mid_bit) begin
      shift <= {rx_s, shift[7:1]};
    end
  end

endmodule

`default_nettype wire

/* apb_uart_regs.sv */
`default_nettype none

module apb_uart_regs (
  input  wire logic                 apb_if,
  input  wire logic                 arst_n,
  input  wire logic                 psel,
  input  wire logic                 penable,
  input  wire logic                 pwrite,
  input  wire logic [7:0]           paddr,
  input  wire logic [31:0]          pwdata,
  input  wire logic [3:0]           pstrb,
  output logic      [31:0]          prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  wire logic                 tx_full,
  input  wire logic                 tx_empty,
  output logic                      tx_push,
  output logic      [7:0]           tx_data,
  input  wire logic                 rx_empty,
  input  wire uart_pkg::rx_item_t   rx_head,
  input  wire logic                 rx_overrun,
  output logic                      rx_pop,
  output logic      [15:0]          divisor,
  output logic                      irq
);

  // bus phase seen in the previous cycle
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_SETUP  = 2'b01,
    ST_ACCESS = 2'b10
  } state_e;

  state_e state;
  state_e state_next;

  logic [31:0] lcr;
  logic [31:0] ier;
  logic        overrun;

  logic                           setup_cycle;
  logic                           wr;
  logic                           rd;
  logic                           err;
  logic [31:0]                    rd_data;
  logic [uart_pkg::LSR_WIDTH-1:0] lsr;
  logic [uart_pkg::IIR_WIDTH-1:0] iir;

  function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = ST_IDLE;
    case (state)
      ST_IDLE: begin
        if (psel && !penable) begin
          state_next = ST_SETUP;
        end
      end
      ST_SETUP: begin
        if (psel && penable) begin
          state_next = ST_ACCESS;
        end else if (psel) begin
          state_next = ST_SETUP;
        end
      end
      ST_ACCESS: begin
        if (psel && !penable) begin
          state_next = ST_SETUP;
        end else if (psel && penable) begin
          state_next = ST_ACCESS;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  // one commit per transfer, on the edge that closes setup
  assign setup_cycle = psel && !penable && (state != ST_SETUP);
  assign wr          = setup_cycle && pwrite;
  assign rd          = setup_cycle && !pwrite;

  always_comb begin
    lsr = '0;
    lsr[uart_pkg::LSR_TX_EMPTY]  = tx_empty;
    lsr[uart_pkg::LSR_TX_FULL]   = tx_full;
    lsr[uart_pkg::LSR_RX_AVAIL]  = !rx_empty;
    lsr[uart_pkg::LSR_OVERRUN]   = overrun;
    lsr[uart_pkg::LSR_FRAME_ERR] = !rx_empty && rx_head.frame_err;

    iir = '0;
    iir[uart_pkg::IIR_RX]       = !rx_empty;
    iir[uart_pkg::IIR_TX_EMPTY] = tx_empty;
    iir[uart_pkg::IIR_LINE]     = overrun || (!rx_empty && rx_head.frame_err);
  end

  // address decode, read mux and error check
  always_comb begin
    err     = 1'b0;
    rd_data = '0;
    case (paddr)
      uart_pkg::ADDR_TDR: err = pwrite && tx_full;
      uart_pkg::ADDR_RDR: begin
        err     = pwrite;
        rd_data = {24'h0, (rx_empty ? 8'h00 : rx_head.data)};
      end
      uart_pkg::ADDR_LCR: rd_data = lcr;
      uart_pkg::ADDR_LSR: begin
        err     = pwrite;
        rd_data = {{(32-uart_pkg::LSR_WIDTH){1'b0}}, lsr};
      end
      uart_pkg::ADDR_IER: rd_data = ier;
      uart_pkg::ADDR_IIR: begin
        err     = pwrite;
        rd_data = {{(32-uart_pkg::IIR_WIDTH){1'b0}}, iir};
      end
      default: err = 1'b1;
    endcase
  end

  assign tx_push = wr && !err && (paddr == uart_pkg::ADDR_TDR) && pstrb[0];
  assign tx_data = pwdata[7:0];
  assign rx_pop  = rd && (paddr == uart_pkg::ADDR_RDR) && !rx_empty;
  assign divisor = lcr[15:0];
  assign pready  = psel && penable;

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      lcr <= '0;
      ier <= '0;
    end else if (wr && !err) begin
      if (paddr == uart_pkg::ADDR_LCR) begin
        lcr <= strb_merge(lcr, pwdata, pstrb);
      end
      if (paddr == uart_pkg::ADDR_IER) begin
        ier <= strb_merge(ier, pwdata, pstrb);
      end
    end
  end

  // sticky overrun, a new overrun wins over the clearing read
  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      overrun <= 1'b0;
    end else if (rx_overrun) begin
      overrun <= 1'b1;
    end else if (rd && (paddr == uart_pkg::ADDR_LSR)) begin
      overrun <= 1'b0;
    end
  end

  always_ff @(posedge apb_if or negedge arst_n) begin
    if (!arst_n) begin
      prdata  <= '0;
      pslverr <= 1'b0;
      irq     <= 1'b0;
    end else begin
      prdata  <= rd ? rd_data : 32'h0;
      pslverr <= setup_cycle && err;
      irq     <= |(iir & ier[uart_pkg::IIR_WIDTH-1:0]);
    end
  end

endmodule

`default_nettype wire

/* apb_uart_top.sv */
`default_nettype none

module apb_uart_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic        apb_if,
  input  wire logic        arst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [7:0]  paddr,
  input  wire logic [31:0] pwdata,
  input  wire logic [3:0]  pstrb,
  output logic      [31:0] prdata,
  output logic             pready,
  output logic             pslverr,
  output logic             txd,
  input  wire logic        rxd,
  output logic             irq
);

  logic               tx_push;
  logic [7:0]         tx_data;
  logic               tx_pop;
  logic [7:0]         tx_head;
  logic               tx_full;
  logic               tx_empty;

  logic               rx_push;
  uart_pkg::rx_item_t rx_item;
  logic               rx_pop;
  uart_pkg::rx_item_t rx_head;
  logic               rx_full;
  logic               rx_empty;
  logic               rx_overrun;

  logic [15:0]        divisor;
  logic               tick;

  apb_uart_regs u_regs (
    .apb_if     (apb_if),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .tx_full    (tx_full),
    .tx_empty   (tx_empty),
    .tx_push    (tx_push),
    .tx_data    (tx_data),
    .rx_empty   (rx_empty),
    .rx_head    (rx_head),
    .rx_overrun (rx_overrun),
    .rx_pop     (rx_pop),
    .divisor    (divisor),
    .irq        (irq)
  );

  uart_baud_gen u_baud (
    .apb_if  (apb_if),
    .arst_n  (arst_n),
    .divisor (divisor),
    .tick    (tick)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .item_t     (logic [7:0])
  ) tx_fifo (
    .apb_if (apb_if),
    .arst_n (arst_n),
    .push   (tx_push),
    .wdata  (tx_data),
    .pop    (tx_pop),
    .rdata  (tx_head),
    .full   (tx_full),
    .empty  (tx_empty)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .item_t     (uart_pkg::rx_item_t)
  ) rx_fifo (
    .apb_if (apb_if),
    .arst_n (arst_n),
    .push   (rx_push),
    .wdata  (rx_item),
    .pop    (rx_pop),
    .rdata  (rx_head),
    .full   (rx_full),
    .empty  (rx_empty)
  );

  uart_tx u_tx (
    .apb_if (apb_if),
    .arst_n (arst_n),
    .tick   (tick),
    .empty  (tx_empty),
    .data   (tx_head),
    .pop    (tx_pop),
    .txd    (txd)
  );

  uart_rx u_rx (
    .apb_if  (apb_if),
    .arst_n  (arst_n),
    .tick    (tick),
    .rxd     (rxd),
    .full    (rx_full),
    .push    (rx_push),
    .item    (rx_item),
    .overrun (rx_overrun)
  );

endmodule

`default_nettype wire

/* tb_apb_uart_checker.sv */
`default_nettype none

module tb_apb_uart_checker #(
  parameter int FIFO_DEPTH = 8
) (
  input wire logic        apb_if,
  input wire logic        arst_n,
  input wire logic        psel,
  input wire logic        penable,
  input wire logic        pwrite,
  input wire logic [7:0]  paddr,
  input wire logic [31:0] pwdata,
  input wire logic [3:0]  pstrb,
  input wire logic [31:0] prdata,
  input wire logic        pready,
  input wire logic        pslverr,
  input wire logic        txd,
  input wire logic        rxd,
  input wire logic        irq
);

  logic [31:0]        lcr_m;
  logic [31:0]        ier_m;
  logic               ovr_m;
  int                 tx_cnt;
  logic [7:0]         tx_q[$];
  uart_pkg::rx_item_t rx_q[$];
  uart_pkg::rx_item_t rx_item_m;
  int                 tx_timer;
  int                 dec_cnt;
  int                 bit_len;
  logic [9:0]         bits;
  logic               prev_txd;
  logic               prev_rxd;
  logic [31:0]        exp_rdata;
  logic               exp_err;
  logic               exp_irq;
  logic               chk_irq;
  logic               access_due;
  logic [2:0]         iir_m;
  int                 err_count = 0;
  int                 tx_pending;
  logic               rx_busy;

  function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] r;
    r = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        r[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic head_ferr();
    return (rx_q.size() > 0) && rx_q[0].frame_err;
  endfunction

  function automatic logic [31:0] build_lsr();
    logic [31:0] r;
    r = '0;
    r[uart_pkg::LSR_TX_EMPTY]  = (tx_cnt == 0);
    r[uart_pkg::LSR_TX_FULL]   = (tx_cnt == FIFO_DEPTH);
    r[uart_pkg::LSR_RX_AVAIL]  = (rx_q.size() > 0);
    r[uart_pkg::LSR_OVERRUN]   = ovr_m;
    r[uart_pkg::LSR_FRAME_ERR] = head_ferr();
    return r;
  endfunction

  function automatic logic [2:0] build_iir();
    logic [2:0] r;
    r = '0;
    r[uart_pkg::IIR_RX]       = (rx_q.size() > 0);
    r[uart_pkg::IIR_TX_EMPTY] = (tx_cnt == 0);
    r[uart_pkg::IIR_LINE]     = ovr_m || head_ferr();
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAILED time=%0t %s expected %h got %h", $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

  // sampled on the falling edge away from the driving edge
  always @(negedge apb_if) begin
    if (!arst_n) begin
      lcr_m      = '0;
      ier_m      = '0;
      ovr_m      = 1'b0;
      tx_cnt     = 0;
      tx_q.delete();
      rx_q.delete();
      tx_timer   = 0;
      dec_cnt    = -1;
      prev_txd   = 1'b1;
      prev_rxd   = 1'b1;
      exp_err    = 1'b0;
      chk_irq    = 1'b0;
      access_due = 1'b0;
    end else begin
      bit_len = uart_pkg::OVERSAMPLE * (int'(lcr_m[15:0]) + 1);

      // a start edge on txd means the transmitter took a byte
      if (tx_timer > 0) begin
        tx_timer--;
      end else if (prev_txd && !txd) begin
        if (tx_cnt == 0) begin
          $display("txd started a frame with no byte queued at %0t", $time);
          err_count++;
        end else begin
          tx_cnt--;
        end
        tx_timer = 10 * bit_len - bit_len / 2;
      end

      // serial line decoder on rxd sampling at mid-bit
      if (dec_cnt < 0) begin
        if (prev_rxd && !rxd) begin
          dec_cnt = 0;
        end
      end else begin
        dec_cnt++;
        if (dec_cnt % bit_len == bit_len / 2) begin
          bits[dec_cnt / bit_len] = rxd;
          if (dec_cnt / bit_len == 0 && rxd) begin
            $display("start bit not held low at %0t", $time);
            err_count++;
          end
          if (dec_cnt / bit_len == 9) begin
            if (tx_q.size() > 0) begin
              check_value("txd data", tx_q.pop_front(), bits[8:1]);
              check_value("txd stop", 1, bits[9]);
            end
            if (rx_q.size() == FIFO_DEPTH) begin
              ovr_m = 1'b1;
            end else begin
              rx_q.push_back('{data: bits[8:1], frame_err: !bits[9]});
            end
            dec_cnt = -1;
          end
        end
      end

      // with zero wait states pready follows the setup cycle
      check_value("pready", access_due, pready);

      if (psel && penable) begin
        check_value("prdata", exp_rdata, prdata);
        check_value("pslverr", exp_err, pslverr);
        if (chk_irq) begin
          check_value("irq", exp_irq, irq);
        end
      end else if (psel) begin
        exp_err   = 1'b0;
        exp_rdata = '0;
        chk_irq   = 1'b0;
        case (paddr)
          uart_pkg::ADDR_TDR: begin
            if (pwrite && tx_cnt == FIFO_DEPTH) begin
              exp_err = 1'b1;
            end else if (pwrite && pstrb[0]) begin
              tx_cnt++;
              tx_q.push_back(pwdata[7:0]);
            end
          end
          uart_pkg::ADDR_RDR: begin
            if (pwrite) begin
              exp_err = 1'b1;
            end else if (rx_q.size() > 0) begin
              rx_item_m = rx_q.pop_front();
              exp_rdata = {24'h0, rx_item_m.data};
            end
          end
          uart_pkg::ADDR_LCR: begin
            if (pwrite) lcr_m = byte_merge(lcr_m, pwdata, pstrb);
            else exp_rdata = lcr_m;
          end
          uart_pkg::ADDR_LSR: begin
            if (pwrite) begin
              exp_err = 1'b1;
            end else begin
              exp_rdata = build_lsr();
              ovr_m     = 1'b0;
            end
          end
          uart_pkg::ADDR_IER: begin
            if (pwrite) ier_m = byte_merge(ier_m, pwdata, pstrb);
            else exp_rdata = ier_m;
          end
          uart_pkg::ADDR_IIR: begin
            if (pwrite) begin
              exp_err = 1'b1;
            end else begin
              iir_m     = build_iir();
              exp_rdata = {29'h0, iir_m};
              exp_irq   = |(iir_m & ier_m[2:0]);
              chk_irq   = 1'b1;
            end
          end
          default: exp_err = 1'b1;
        endcase
      end

      access_due = psel && !penable;
      prev_txd   = txd;
      prev_rxd   = rxd;
    end
    tx_pending = tx_q.size();
    rx_busy    = (dec_cnt >= 0);
  end

endmodule

`default_nettype wire

/* tb_apb_uart.sv */
`default_nettype none

module tb_apb_uart;

  localparam int FIFO_DEPTH = 8;
  localparam int DIV        = 3;
  localparam int BIT_LEN    = uart_pkg::OVERSAMPLE * (DIV + 1);
  // upper bound on frames sent over the whole run
  localparam int FRAMES     = 30;
  localparam int WD_CYCLES  = FRAMES * 10 * BIT_LEN * 2 + 5000;

  logic        apb_if;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        txd;
  logic        rxd;
  logic        irq;
  logic        loopback;
  logic        rxd_inj;
  logic [15:0] lfsr;

  assign rxd = loopback ? txd : rxd_inj;

  apb_uart_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .apb_if  (apb_if),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .txd     (txd),
    .rxd     (rxd),
    .irq     (irq)
  );

  tb_apb_uart_checker #(.FIFO_DEPTH(FIFO_DEPTH)) chk0 (
    .apb_if  (apb_if),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .txd     (txd),
    .rxd     (rxd),
    .irq     (irq)
  );

  initial begin
    apb_if = 1'b0;
    forever #2 apb_if = ~apb_if;
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
    @(posedge apb_if);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    pstrb   <= strb;
    @(posedge apb_if);
    penable <= 1'b1;
    @(posedge apb_if);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge apb_if);
      rxd_inj <= bits[i];
      repeat (BIT_LEN - 1) @(posedge apb_if);
    end
    @(posedge apb_if);
    rxd_inj <= 1'b1;
    repeat (2 * BIT_LEN) @(posedge apb_if);
  endtask

  // leave time for the receiver to push after the line goes quiet
  task automatic wait_line_idle();
    @(negedge apb_if);
    while (chk0.tx_pending != 0 || chk0.rx_busy) begin
      @(negedge apb_if);
    end
    repeat (2 * BIT_LEN) @(posedge apb_if);
  endtask

  initial begin
    repeat (WD_CYCLES) @(posedge apb_if);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    lfsr      = 16'd28;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    loopback  = 1'b1;
    rxd_inj   = 1'b1;
    arst_n    = 1'b0;
    repeat (4) @(posedge apb_if);
    arst_n <= 1'b1;

    // strobed register writes and readback
    for (int i = 0; i < 6; i++) begin
      apb_transfer(1'b1, uart_pkg::ADDR_LCR, rand_bits(32), rand_bits(4));
      apb_transfer(1'b0, uart_pkg::ADDR_LCR, '0, '0);
      apb_transfer(1'b1, uart_pkg::ADDR_IER, rand_bits(32), rand_bits(4));
      apb_transfer(1'b0, uart_pkg::ADDR_IER, '0, '0);
    end
    apb_transfer(1'b1, uart_pkg::ADDR_LCR, 32'(DIV), 4'hF);
    apb_transfer(1'b1, uart_pkg::ADDR_IER, 32'h0, 4'hF);

    // unmapped and read-only accesses
    for (int i = 0; i < 8; i++) begin
      apb_transfer(1'b1, 8'(rand_bits(8)) | 8'h40, rand_bits(32), 4'hF);
      apb_transfer(1'b0, 8'(rand_bits(8)) | 8'h40, '0, '0);
    end
    apb_transfer(1'b1, uart_pkg::ADDR_RDR, rand_bits(32), 4'hF);
    apb_transfer(1'b1, uart_pkg::ADDR_LSR, rand_bits(32), 4'hF);
    apb_transfer(1'b1, uart_pkg::ADDR_IIR, rand_bits(32), 4'hF);
    apb_transfer(1'b0, uart_pkg::ADDR_LCR, '0, '0);
    apb_transfer(1'b0, uart_pkg::ADDR_IER, '0, '0);

    // loopback transmit and receive
    for (int i = 0; i < 6; i++) begin
      apb_transfer(1'b1, uart_pkg::ADDR_TDR, rand_bits(8), 4'h1);
    end
    wait_line_idle();
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);
    for (int i = 0; i < 7; i++) begin
      apb_transfer(1'b0, uart_pkg::ADDR_RDR, '0, '0);
    end
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);

    // overfill the transmit FIFO
    for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
      apb_transfer(1'b1, uart_pkg::ADDR_TDR, rand_bits(8), 4'h1);
    end
    wait_line_idle();
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      apb_transfer(1'b0, uart_pkg::ADDR_RDR, '0, '0);
    end
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);

    // receive overrun from injected frames
    loopback <= 1'b0;
    repeat (2 * BIT_LEN) @(posedge apb_if);
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      send_frame(rand_bits(8), 1'b1);
    end
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      apb_transfer(1'b0, uart_pkg::ADDR_RDR, '0, '0);
    end

    // framing error and interrupt causes
    apb_transfer(1'b1, uart_pkg::ADDR_IER, rand_bits(3), 4'h1);
    send_frame(rand_bits(8), 1'b0);
    apb_transfer(1'b0, uart_pkg::ADDR_LSR, '0, '0);
    apb_transfer(1'b0, uart_pkg::ADDR_IIR, '0, '0);
    apb_transfer(1'b1, uart_pkg::ADDR_IER, 32'h7, 4'h1);
    apb_transfer(1'b0, uart_pkg::ADDR_IIR, '0, '0);
    apb_transfer(1'b0, uart_pkg::ADDR_RDR, '0, '0);
    apb_transfer(1'b0, uart_pkg::ADDR_IIR, '0, '0);
    repeat (4) @(posedge apb_if);

    $display("checks done with %0d errors", chk0.err_count);
    if (chk0.err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* apb_uart_top.f */
uart_pkg.sv
uart_fifo.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
apb_uart_regs.sv
apb_uart_top.sv
tb_apb_uart_checker.sv
tb_apb_uart.sv

/* Bender.yml */
package:
  name: apb_uart

sources:
  - uart_pkg.sv
  - uart_fifo.sv
  - uart_baud_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - apb_uart_regs.sv
  - apb_uart_top.sv
  - target: simulation
    files:
      - tb_apb_uart_checker.sv
      - tb_apb_uart.sv
